/* build.f */
rtl/lc3b_types.sv
rtl/cdb_pkg.sv
rtl/operand_decode.sv
rtl/alu_res_station.sv
rtl/lc3b_alu.sv
rtl/cdb_arbiter.sv
rtl/alu_cluster.sv
tests/alu_cluster_tb.sv

/* rtl/alu_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_cluster
	import lc3b_types::*;
	import cdb_pkg::*;
#(
	parameter int NUM_STATIONS = NUM_STATIONS_DEFAULT,
	localparam int SEL_W = (NUM_STATIONS > 1) ? $clog2(NUM_STATIONS) : 1
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     flush,
	input  logic     issue,
	input  lc3b_word instr,
	input  cdb_tag_t dest_tag,
	input  lc3b_word src1_value,
	input  cdb_tag_t src1_tag,
	input  lc3b_word src2_value,
	input  cdb_tag_t src2_tag,
	input  logic     ext_cdb_valid,
	input  cdb_tag_t ext_cdb_tag,
	input  lc3b_word ext_cdb_data,
	output logic     full,
	output logic     cdb_valid,
	output cdb_tag_t cdb_tag,
	output lc3b_word cdb_data
);

	alu_op_t dec_op;
	lc3b_word dec_vj;
	lc3b_word dec_vk;
	cdb_tag_t dec_qj;
	cdb_tag_t dec_qk;

	logic [NUM_STATIONS-1:0] load;
	logic [NUM_STATIONS-1:0] busy;
	logic [NUM_STATIONS-1:0] ready;
	logic [NUM_STATIONS-1:0] grant;
	logic [SEL_W-1:0] sel;
	alu_op_t st_op [NUM_STATIONS];
	lc3b_word st_vj [NUM_STATIONS];
	lc3b_word st_vk [NUM_STATIONS];
	cdb_tag_t [NUM_STATIONS-1:0] st_dest;
	lc3b_word alu_f;

	operand_decode decode (
		.instr(instr), .src1_value(src1_value), .src2_value(src2_value),
		.src1_tag(src1_tag), .src2_tag(src2_tag),
		.ext_cdb_valid(ext_cdb_valid), .ext_cdb_tag(ext_cdb_tag), .ext_cdb_data(ext_cdb_data),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.op(dec_op), .vj(dec_vj), .vk(dec_vk), .qj(dec_qj), .qk(dec_qk)
	);

	// Issue goes to the lowest free station
	always_comb
	begin
		load = '0;
		for (int i = NUM_STATIONS - 1; i >= 0; i--)
		begin
			if (!busy[i])
			begin
				load = '0;
				load[i] = issue;
			end
		end
	end

	assign full = &busy;

	for (genvar i = 0; i < NUM_STATIONS; i++)
	begin : g_station
		alu_res_station station (
			.clk(clk), .rst_n(rst_n), .flush(flush), .load(load[i]),
			.op(dec_op), .vj(dec_vj), .vk(dec_vk), .qj(dec_qj), .qk(dec_qk),
			.dest_tag(dest_tag),
			.ext_cdb_valid(ext_cdb_valid), .ext_cdb_tag(ext_cdb_tag),
			.ext_cdb_data(ext_cdb_data),
			.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
			.grant(grant[i]), .busy(busy[i]), .ready(ready[i]),
			.op_out(st_op[i]), .vj_out(st_vj[i]), .vk_out(st_vk[i]), .dest_out(st_dest[i])
		);
	end

	cdb_arbiter #(.NUM_STATIONS(NUM_STATIONS)) arbiter (
		.clk(clk), .rst_n(rst_n), .flush(flush), .ready(ready),
		.alu_result(alu_f), .dest_tags(st_dest), .grant(grant), .sel(sel),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
	);

	lc3b_alu alu (
		.op(st_op[sel]),
		.a(st_vj[sel]),
		.b(st_vk[sel]),
		.f(alu_f)
	);

endmodule

`default_nettype wire

/* rtl/alu_res_station.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_res_station
	import lc3b_types::*;
	import cdb_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     flush,
	input  logic     load,
	input  alu_op_t  op,
	input  lc3b_word vj,
	input  lc3b_word vk,
	input  cdb_tag_t qj,
	input  cdb_tag_t qk,
	input  cdb_tag_t dest_tag,
	input  logic     ext_cdb_valid,
	input  cdb_tag_t ext_cdb_tag,
	input  lc3b_word ext_cdb_data,
	input  logic     cdb_valid,
	input  cdb_tag_t cdb_tag,
	input  lc3b_word cdb_data,
	input  logic     grant,
	output logic     busy,
	output logic     ready,
	output alu_op_t  op_out,
	output lc3b_word vj_out,
	output lc3b_word vk_out,
	output cdb_tag_t dest_out
);

	cdb_tag_t qj_r;
	cdb_tag_t qk_r;

	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
			busy <= 1'b0;
		else if (load)
			busy <= 1'b1;
		else if (grant)
			busy <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			op_out   <= op;
			vj_out   <= vj;
			vk_out   <= vk;
			qj_r     <= qj;
			qk_r     <= qk;
			dest_out <= dest_tag;
		end
		else
		begin
			// Tags are unique, so at most one bus can match a waiting operand
			if (qj_r != TAG_READY && ext_cdb_valid && ext_cdb_tag == qj_r)
			begin
				vj_out <= ext_cdb_data;
				qj_r   <= TAG_READY;
			end
			else if (qj_r != TAG_READY && cdb_valid && cdb_tag == qj_r)
			begin
				vj_out <= cdb_data;
				qj_r   <= TAG_READY;
			end

			if (qk_r != TAG_READY && ext_cdb_valid && ext_cdb_tag == qk_r)
			begin
				vk_out <= ext_cdb_data;
				qk_r   <= TAG_READY;
			end
			else if (qk_r != TAG_READY && cdb_valid && cdb_tag == qk_r)
			begin
				vk_out <= cdb_data;
				qk_r   <= TAG_READY;
			end
		end
	end

	assign ready = busy && qj_r == TAG_READY && qk_r == TAG_READY;

endmodule

`default_nettype wire

/* rtl/cdb_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter
	import lc3b_types::*;
	import cdb_pkg::*;
#(
	parameter int NUM_STATIONS = NUM_STATIONS_DEFAULT,
	localparam int SEL_W = (NUM_STATIONS > 1) ? $clog2(NUM_STATIONS) : 1
)
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       flush,
	input  logic [NUM_STATIONS-1:0]    ready,
	input  lc3b_word                   alu_result,
	input  cdb_tag_t [NUM_STATIONS-1:0] dest_tags,
	output logic [NUM_STATIONS-1:0]    grant,
	output logic [SEL_W-1:0]           sel,
	output logic                       cdb_valid,
	output cdb_tag_t                   cdb_tag,
	output lc3b_word                   cdb_data
);

	// Scanning downward leaves the lowest ready station as the winner
	always_comb
	begin
		grant = '0;
		sel = '0;
		for (int i = NUM_STATIONS - 1; i >= 0; i--)
		begin
			if (ready[i])
			begin
				grant = '0;
				grant[i] = 1'b1;
				sel = SEL_W'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= |ready;
	end

	always_ff @(posedge clk)
	begin
		if (|ready)
		begin
			cdb_tag  <= dest_tags[sel];
			cdb_data <= alu_result;
		end
	end

endmodule

`default_nettype wire

/* rtl/cdb_pkg.sv */
`default_nettype none

package cdb_pkg;

	localparam int TAG_W = 3;

	typedef logic [TAG_W-1:0] cdb_tag_t;

	// Tag 0 marks an operand whose value is already present
	localparam cdb_tag_t TAG_READY = '0;

	localparam int NUM_STATIONS_DEFAULT = 2;

endpackage

`default_nettype wire

/* rtl/lc3b_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_alu
	import lc3b_types::*;
(
	input  alu_op_t  op,
	input  lc3b_word a,
	input  lc3b_word b,
	output lc3b_word f
);

	always_comb
	begin
		case (op)
			alu_add:
				f = a + b;
			alu_and:
				f = a & b;
			alu_not:
				f = ~a;
			alu_lshf:
				f = a << b[3:0];
			alu_rshfl:
				f = a >> b[3:0];
			// Sign bit fills from the left
			alu_rshfa:
				f = lc3b_word'($signed(a) >>> b[3:0]);
			default:
				f = a + b;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/lc3b_types.sv */
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;

	typedef enum logic [3:0] {
		op_br, op_add, op_ldb, op_stb, op_jsr, op_and, op_ldr, op_str,
		op_rti, op_not, op_ldi, op_sti, op_jmp, op_shf, op_lea, op_trap
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add, alu_and, alu_not, alu_lshf, alu_rshfl, alu_rshfa
	} alu_op_t;

	typedef struct packed {
		lc3b_opcode opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic imm;
		logic [1:0] pad;
		logic [2:0] sr2;
	} lc3b_reg_form_t;

	typedef struct packed {
		lc3b_opcode opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic imm;
		logic [4:0] imm5;
	} lc3b_imm_form_t;

	// Bit 5 selects arithmetic, bit 4 selects a right shift
	typedef struct packed {
		lc3b_opcode opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic arith;
		logic dir;
		logic [3:0] imm4;
	} lc3b_shf_form_t;

	typedef union packed {
		lc3b_reg_form_t reg_form;
		lc3b_imm_form_t imm_form;
		lc3b_shf_form_t shf_form;
	} lc3b_instr_u;

endpackage

`default_nettype wire

/* rtl/operand_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_decode
	import lc3b_types::*;
	import cdb_pkg::*;
(
	input  lc3b_instr_u instr,
	input  lc3b_word    src1_value,
	input  lc3b_word    src2_value,
	input  cdb_tag_t    src1_tag,
	input  cdb_tag_t    src2_tag,
	input  logic        ext_cdb_valid,
	input  cdb_tag_t    ext_cdb_tag,
	input  lc3b_word    ext_cdb_data,
	input  logic        cdb_valid,
	input  cdb_tag_t    cdb_tag,
	input  lc3b_word    cdb_data,
	output alu_op_t     op,
	output lc3b_word    vj,
	output lc3b_word    vk,
	output cdb_tag_t    qj,
	output cdb_tag_t    qk
);

	// A source broadcast in the issue cycle would be missed by the station otherwise
	function automatic void resolve(input cdb_tag_t tag, input lc3b_word value,
			output lc3b_word v, output cdb_tag_t q);
		v = value;
		q = tag;
		if (tag != TAG_READY && ext_cdb_valid && ext_cdb_tag == tag)
		begin
			v = ext_cdb_data;
			q = TAG_READY;
		end
		else if (tag != TAG_READY && cdb_valid && cdb_tag == tag)
		begin
			v = cdb_data;
			q = TAG_READY;
		end
	endfunction

	always_comb
	begin
		resolve(src1_tag, src1_value, vj, qj);
		resolve(src2_tag, src2_value, vk, qk);
		op = alu_add;
		case (instr.reg_form.opcode)
			op_and:
				op = alu_and;
			op_not:
				op = alu_not;
			op_shf:
				if (!instr.shf_form.dir)
					op = alu_lshf;
				else if (instr.shf_form.arith)
					op = alu_rshfa;
				else
					op = alu_rshfl;
			default:
				op = alu_add;
		endcase

		if (instr.reg_form.opcode == op_shf)
		begin
			vk = {12'b0, instr.shf_form.imm4};
			qk = TAG_READY;
		end
		else if (instr.reg_form.opcode == op_not)
		begin
			vk = '0;
			qk = TAG_READY;
		end
		else if (instr.reg_form.imm)
		begin
			vk = {{11{instr.imm_form.imm5[4]}}, instr.imm_form.imm5};
			qk = TAG_READY;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the ALU cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module alu_cluster_tb \
	-o alu_cluster_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/alu_cluster_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi

if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

echo "Simulation PASSED"
exit 0

/* tests/alu_cluster_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_cluster_tb;

	localparam logic [3:0] OPC_ADD = 4'h1;
	localparam logic [3:0] OPC_AND = 4'h5;
	// Reset, six tests and a few idle cycles between them
	localparam int TEST_CYCLES = 16 + 12 + 10 + 18 + 10 + 10 + 18 + 6;
	localparam int TIMEOUT_NS = TEST_CYCLES * 8 + 400;

	logic clk = 1'b0;
	logic rst_n;
	logic flush;
	logic issue;
	logic [15:0] instr;
	logic [2:0] dest_tag;
	logic [15:0] src1_value;
	logic [2:0] src1_tag;
	logic [15:0] src2_value;
	logic [2:0] src2_tag;
	logic ext_cdb_valid;
	logic [2:0] ext_cdb_tag;
	logic [15:0] ext_cdb_data;
	logic full;
	logic cdb_valid;
	logic [2:0] cdb_tag;
	logic [15:0] cdb_data;

	logic [31:0] lcg_state = 32'h5dd2;
	logic [18:0] exp_q [$];

	alu_cluster #(.NUM_STATIONS(2)) uut (
		.clk(clk), .rst_n(rst_n), .flush(flush), .issue(issue), .instr(instr),
		.dest_tag(dest_tag), .src1_value(src1_value), .src1_tag(src1_tag),
		.src2_value(src2_value), .src2_tag(src2_tag),
		.ext_cdb_valid(ext_cdb_valid), .ext_cdb_tag(ext_cdb_tag), .ext_cdb_data(ext_cdb_data),
		.full(full), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
	);

	always #4 clk = ~clk;

	initial
	begin
		#(TIMEOUT_NS);
		$display("Simulation ran past its time limit before the tests finished");
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [15:0] rand_word();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	// Expected result of an LC-3b ALU instruction, decoded from the raw word
	function automatic logic [15:0] model(input logic [15:0] word, input logic [15:0] a,
			input logic [15:0] b);
		logic [15:0] opnd;
		logic [15:0] f;
		int amt;
		opnd = word[5] ? {{11{word[4]}}, word[4:0]} : b;
		amt = int'(word[3:0]);
		case (word[15:12])
			4'h5:
				f = a & opnd;
			4'h9:
				f = ~a;
			4'hd:
			begin
				f = a;
				if (!word[4])
					f = a << amt;
				else if (!word[5])
					f = a >> amt;
				else
					for (int k = 0; k < amt; k++)
						f = {f[15], f[15:1]};
			end
			default:
				f = a + opnd;
		endcase
		return f;
	endfunction

	task automatic fail_text(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_idle();
		check_value("cdb_valid", {15'b0, cdb_valid}, 16'd0);
	endtask

	task automatic check_full(input logic exp);
		check_value("full", {15'b0, full}, {15'b0, exp});
	endtask

	task automatic check_result();
		logic [18:0] exp;
		assert (exp_q.size() > 0)
		else
			fail_text("A result appeared with no expected result queued");
		exp = exp_q.pop_front();
		check_value("cdb_valid", {15'b0, cdb_valid}, 16'd1);
		check_value("cdb_tag", {13'b0, cdb_tag}, {13'b0, exp[18:16]});
		check_value("cdb_data", cdb_data, exp[15:0]);
	endtask

	task automatic set_issue(input logic [15:0] word, input logic [2:0] dest,
			input logic [15:0] v1, input logic [2:0] t1, input logic [15:0] v2,
			input logic [2:0] t2);
		issue = 1'b1;
		instr = word;
		dest_tag = dest;
		src1_value = v1;
		src1_tag = t1;
		src2_value = v2;
		src2_tag = t2;
	endtask

	task automatic issue_one(input logic [15:0] word, input logic [2:0] dest,
			input logic [15:0] v1, input logic [2:0] t1, input logic [15:0] v2,
			input logic [2:0] t2);
		set_issue(word, dest, v1, t1, v2, t2);
		@(negedge clk);
		issue = 1'b0;
	endtask

	task automatic ext_broadcast(input logic [2:0] tag, input logic [15:0] data);
		ext_cdb_valid = 1'b1;
		ext_cdb_tag = tag;
		ext_cdb_data = data;
		@(negedge clk);
		ext_cdb_valid = 1'b0;
	endtask

	// Ready operands give the result on the second edge after issue
	task automatic run_ready_op(input logic [15:0] word, input logic [2:0] dest,
			input logic [15:0] a, input logic [15:0] b, input logic [2:0] t2);
		exp_q.push_back({dest, model(word, a, b)});
		issue_one(word, dest, a, 3'd0, b, t2);
		check_idle();
		@(negedge clk);
		check_result();
	endtask

	task automatic test_register_ops();
		logic [15:0] word;
		for (int i = 0; i < 6; i++)
		begin
			word = {(i % 2 == 1) ? OPC_AND : OPC_ADD, 3'(i), 3'(i + 1), 3'b000, 3'(i + 2)};
			run_ready_op(word, 3'(i % 7 + 1), rand_word(), rand_word(), 3'd0);
		end
	endtask

	task automatic test_immediate_ops();
		run_ready_op({OPC_ADD, 3'd1, 3'd2, 1'b1, 5'b11001}, 3'd2, rand_word(), rand_word(), 3'd5);
		run_ready_op({OPC_ADD, 3'd1, 3'd2, 1'b1, 5'b01101}, 3'd3, rand_word(), rand_word(), 3'd5);
		run_ready_op({OPC_AND, 3'd3, 3'd4, 1'b1, 5'b11111}, 3'd4, rand_word(), rand_word(), 3'd6);
		run_ready_op({OPC_AND, 3'd3, 3'd4, 1'b1, 5'b01010}, 3'd5, rand_word(), rand_word(), 3'd6);
		run_ready_op({4'h9, 3'd5, 3'd6, 6'b111111}, 3'd6, rand_word(), rand_word(), 3'd7);
	endtask

	task automatic test_shifts();
		logic [15:0] a;
		logic [15:0] amt;
		for (int i = 0; i < 9; i++)
		begin
			a = rand_word();
			amt = rand_word();
			if (i % 3 == 2 && i < 6)
				a[15] = 1'b1;
			run_ready_op({4'hd, 3'd1, 3'd2, i % 3 == 2, i % 3 != 0, amt[3:0]}, 3'(i % 7 + 1),
				a, rand_word(), 3'd0);
		end
	endtask

	task automatic test_waiting_sources();
		logic [15:0] word;
		logic [15:0] a;
		logic [15:0] b;
		word = {OPC_ADD, 3'd1, 3'd2, 3'b000, 3'd3};
		issue_one(word, 3'd6, rand_word(), 3'd3, rand_word(), 3'd4);
		check_idle();
		ext_broadcast(3'd5, rand_word());
		check_idle();
		ext_broadcast(3'd2, rand_word());
		check_idle();
		a = rand_word();
		ext_broadcast(3'd3, a);
		check_idle();
		b = rand_word();
		exp_q.push_back({3'd6, model(word, a, b)});
		ext_broadcast(3'd4, b);
		check_idle();
		@(negedge clk);
		check_result();
	endtask

	task automatic test_contention();
		logic [15:0] d;
		logic [15:0] b1;
		logic [15:0] b2;
		logic [15:0] c;
		logic [15:0] r1;
		d = rand_word();
		b1 = rand_word();
		b2 = rand_word();
		c = rand_word();
		r1 = model({OPC_ADD, 9'd0, 3'd0}, d, b1);
		exp_q.push_back({3'd1, r1});
		exp_q.push_back({3'd2, model({OPC_AND, 9'd0, 3'd0}, d, b2)});
		exp_q.push_back({3'd3, model({OPC_ADD, 9'd0, 3'd0}, r1, c)});
		issue_one({OPC_ADD, 3'd1, 3'd2, 3'b000, 3'd3}, 3'd1, 16'd0, 3'd7, b1, 3'd0);
		check_full(1'b0);
		issue_one({OPC_AND, 3'd2, 3'd2, 3'b000, 3'd4}, 3'd2, 16'd0, 3'd7, b2, 3'd0);
		check_full(1'b1);
		ext_broadcast(3'd7, d);
		check_idle();
		check_full(1'b1);
		@(negedge clk);
		check_result();
		check_full(1'b0);
		// Source tag 1 is the result now on the cluster bus
		set_issue({OPC_ADD, 3'd3, 3'd1, 3'b000, 3'd5}, 3'd3, 16'd0, 3'd1, c, 3'd0);
		@(negedge clk);
		issue = 1'b0;
		check_result();
		@(negedge clk);
		check_result();
	endtask

	task automatic test_flush();
		issue_one({OPC_ADD, 3'd1, 3'd2, 3'b000, 3'd3}, 3'd4, 16'd0, 3'd5, rand_word(), 3'd0);
		check_full(1'b0);
		issue_one({OPC_AND, 3'd2, 3'd2, 3'b000, 3'd4}, 3'd6, 16'd0, 3'd7, rand_word(), 3'd0);
		check_full(1'b1);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		check_full(1'b0);
		ext_broadcast(3'd5, rand_word());
		ext_broadcast(3'd7, rand_word());
		for (int i = 0; i < 10; i++)
		begin
			check_idle();
			@(negedge clk);
		end
		check_full(1'b0);
		run_ready_op({OPC_AND, 3'd1, 3'd2, 3'b000, 3'd3}, 3'd5, rand_word(), rand_word(), 3'd0);
	endtask

	initial
	begin
		rst_n = 1'b0;
		flush = 1'b0;
		issue = 1'b0;
		instr = '0;
		dest_tag = '0;
		src1_value = '0;
		src1_tag = '0;
		src2_value = '0;
		src2_tag = '0;
		ext_cdb_valid = 1'b0;
		ext_cdb_tag = '0;
		ext_cdb_data = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_idle();
		check_full(1'b0);
		test_register_ops();
		test_immediate_ops();
		test_shifts();
		test_waiting_sources();
		test_contention();
		test_flush();
		assert (exp_q.size() == 0)
		else
			fail_text("Some expected results never appeared on the cluster bus");
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
